//--- if_stage.f
rtl/fetch_pkg.sv
rtl/rvc_pkg.sv
rtl/pc_select.sv
rtl/prefetch_unit.sv
rtl/instr_aligner.sv
rtl/compressed_decoder.sv
rtl/if_stage.sv
tests/tb_if_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_if_stage -f if_stage.f

output=$(./obj_dir/Vtb_if_stage 2>&1 || true)
echo "$output"

if grep -q "TESTS PASSED" <<< "$output"; then
  exit 0
fi
exit 1

//--- tests/tb_if_stage.sv
// Fetch stage testbench with an instruction bus memory model, reference RVC decoder and scoreboard
`timescale 1ns/1ps

module tb_if_stage import fetch_pkg::*; ();

  // Program memory size in halfwords
  localparam int MEM_HW = 1024;
  // Cycle budget for one wait
  localparam int MAX_CYCLES = 3000;
  localparam ctrl_fetch_t IDLE = '0;

  logic                    clk;
  logic                    rst_n;
  logic [XLEN-1:0]         boot_addr;
  logic [XLEN-1:0]         jump_target;
  logic [XLEN-1:0]         branch_target;
  logic [XLEN-1:0]         mepc;
  logic [MTVEC_ADDR_W-1:0] mtvec_addr;
  ctrl_fetch_t             ctrl;
  bus_resp_t               bus_resp;
  bus_req_t                bus_req;
  logic                    id_ready;
  if_id_t                  if_id;
  logic                    if_busy;
  logic                    mtvec_init;

  // Program as halfwords for the bus model
  logic [15:0] prog [MEM_HW];
  // Granted reads waiting for their response in grant order
  logic [31:0] resp_addr_q [$];
  int          resp_due_q [$];

  int          cyc;
  int          n_checked;
  int          n_comp;
  int          n_straddle;
  int          n_stalls;
  logic [31:0] exp_pc;
  logic [15:0] exp_last_c;
  bit          gnt_rand;
  bit          ready_rand;
  bit          hold_pending;
  if_id_t      held;
  bit          req_pending;
  logic [31:0] req_addr;

  if_stage dut_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .boot_addr_i     (boot_addr),
    .jump_target_i   (jump_target),
    .branch_target_i (branch_target),
    .mepc_i          (mepc),
    .mtvec_addr_i    (mtvec_addr),
    .ctrl_i          (ctrl),
    .bus_resp_i      (bus_resp),
    .bus_req_o       (bus_req),
    .id_ready_i      (id_ready),
    .if_id_o         (if_id),
    .if_busy_o       (if_busy),
    .mtvec_init_o    (mtvec_init)
  );

  always #20 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
      else report_error($sformatf("ERROR %s got %h expected %h", name, got, exp));
  endtask

  function automatic int hw_index(input logic [31:0] addr);
    return int'(addr[10:1]);
  endfunction

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return {prog[hw_index(addr + 32'd2)], prog[hw_index(addr)]};
  endfunction

  // Returns {illegal, expanded instruction}
  function automatic logic [32:0] ref_expand(input logic [15:0] c);
    logic [31:0] imm;
    logic [31:0] off;
    logic [4:0]  rd;
    logic [4:0]  rs2;
    rd  = c[11:7];
    rs2 = c[6:2];
    imm = {{26{c[12]}}, c[12], c[6:2]};
    // Jump offset bits 11|4|9:8|10|6|7|3:1|5 sit in c[12:2]
    off = {{20{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
    if (c[1:0] == 2'b01 && c[15:13] == 3'b000)
      return {1'b0, imm[11:0], rd, 3'b000, rd, 7'h13};
    if (c[1:0] == 2'b01 && c[15:13] == 3'b010)
      return {1'b0, imm[11:0], 5'd0, 3'b000, rd, 7'h13};
    if (c[1:0] == 2'b01 && c[15:13] == 3'b101)
      return {1'b0, off[20], off[10:1], off[11], off[19:12], 5'd0, 7'h6f};
    if (c[1:0] == 2'b10 && c[15:12] == 4'b1000 && rs2 != 5'd0)
      return {1'b0, 7'h00, rs2, 5'd0, 3'b000, rd, 7'h33};
    if (c[1:0] == 2'b10 && c[15:12] == 4'b1001 && rs2 != 5'd0)
      return {1'b0, 7'h00, rs2, rd, 3'b000, rd, 7'h33};
    return {1'b1, 16'h0000, c};
  endfunction

  function automatic logic [31:0] redirect_target(input pc_mux_e mux, input logic [4:0] irq);
    logic [31:0] t;
    case (mux)
      PC_BOOT:     t = boot_addr & ~32'h3;
      PC_JUMP:     t = jump_target;
      PC_BRANCH:   t = branch_target;
      PC_MRET:     t = mepc;
      PC_TRAP_EXC: t = 32'(mtvec_addr) << 7;
      default:     t = (32'(mtvec_addr) << 7) | (32'(irq) << 2);
    endcase
    return t & ~32'h1;
  endfunction

  // Mixed mode writes compressed kinds among the 32-bit instructions
  task automatic fill_program(input int start_hw, input int n_hw, input bit mixed);
    int          i;
    int          kind;
    logic [15:0] h;
    i = 0;
    while (i < n_hw) begin
      h    = 16'($urandom);
      kind = mixed ? int'($urandom % 10) : 9;
      if (kind >= 7 && i + 1 < n_hw) begin
        prog[(start_hw + i) % MEM_HW]     = {h[15:2], 2'b11};
        prog[(start_hw + i + 1) % MEM_HW] = 16'($urandom);
        i += 2;
      end else begin
        case (kind)
          0:       h = {3'b000, h[12:2], 2'b01};
          1:       h = {3'b010, h[12:2], 2'b01};
          2:       h = {3'b101, h[12:2], 2'b01};
          // Bit 12 picks mv or add
          3, 4:    h = {3'b100, h[12:7], (h[6:2] == 5'd0) ? 5'd1 : h[6:2], 2'b10};
          5:       h = {h[15:2], 2'b00};
          // C.jr lies outside the supported subset
          6:       h = {4'b1000, h[11:7], 5'd0, 2'b10};
          default: h = {h[15:2], 2'b01};
        endcase
        prog[(start_hw + i) % MEM_HW] = h;
        i += 1;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Scoreboard and bus model
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_entry();
    logic [15:0] lo;
    logic [32:0] exp;
    bit          exp_c;
    lo    = prog[hw_index(exp_pc)];
    exp_c = lo[1:0] != 2'b11;
    if (exp_c) begin
      exp        = ref_expand(lo);
      exp_last_c = lo;
    end else begin
      exp = {1'b0, prog[hw_index(exp_pc + 32'd2)], lo};
    end
    check_value("if_id_o.pc", if_id.pc, exp_pc);
    check_value("if_id_o.instr", if_id.instr, exp[31:0]);
    check_value("if_id_o.compressed", 32'(if_id.compressed), 32'(exp_c));
    check_value("if_id_o.illegal", 32'(if_id.illegal), 32'(exp[32]));
    check_value("if_id_o.compressed_instr", 32'(if_id.compressed_instr), 32'(exp_last_c));
    n_comp += int'(exp_c);
    if (!exp_c && exp_pc[1])
      n_straddle++;
    exp_pc = exp_pc + (exp_c ? 32'd2 : 32'd4);
    n_checked++;
  endtask

  // ID takes the entry on the coming edge when id_ready is high
  task automatic check_output();
    if (hold_pending) begin
      assert (if_id == held)
        else report_error($sformatf("ERROR if_id_o got %h expected %h", if_id, held));
    end
    hold_pending = if_id.valid && !id_ready;
    held         = if_id;
    n_stalls    += int'(hold_pending);
    if (if_id.valid && id_ready)
      check_entry();
  endtask

  task automatic check_request(input ctrl_fetch_t c);
    int due;
    check_value("mtvec_init_o", 32'(mtvec_init), 32'(c.pc_set && c.pc_mux == PC_BOOT));
    if (req_pending && !c.pc_set) begin
      assert (bus_req.req && bus_req.addr == req_addr)
        else report_error("bus request dropped or moved before its grant");
    end
    req_pending = bus_req.req && !bus_resp.gnt;
    req_addr    = bus_req.addr;
    if (bus_req.req && bus_resp.gnt) begin
      check_value("bus_req_o.addr[1:0]", 32'(bus_req.addr[1:0]), 32'h0);
      due = cyc + (gnt_rand ? 1 + int'($urandom % 3) : 1);
      // Responses stay in order at one per cycle
      if (resp_due_q.size() > 0 && due <= resp_due_q[$])
        due = resp_due_q[$] + 1;
      resp_addr_q.push_back(bus_req.addr);
      resp_due_q.push_back(due);
      assert (resp_due_q.size() <= FIFO_DEPTH)
        else report_error("more reads in flight than prefetch buffer slots");
    end
  endtask

  // One cycle with all inputs changing on the falling edge
  task automatic step(input ctrl_fetch_t c);
    @(negedge clk);
    cyc++;
    // Busy while granted reads are still unanswered
    check_value("if_busy_o", 32'(if_busy), 32'(resp_due_q.size() != 0));
    id_ready = (c.pc_set || !ready_rand) ? 1'b1 : 1'(($urandom % 3) != 0);
    check_output();
    if (resp_due_q.size() > 0 && resp_due_q[0] <= cyc) begin
      bus_resp.rvalid = 1'b1;
      bus_resp.rdata  = mem_word(resp_addr_q.pop_front());
      void'(resp_due_q.pop_front());
    end else begin
      bus_resp.rvalid = 1'b0;
      bus_resp.rdata  = 32'h0;
    end
    bus_resp.gnt = gnt_rand ? 1'(($urandom % 4) != 0) : 1'b1;
    ctrl         = c;
    #1;
    check_request(c);
  endtask

  task automatic redirect(input pc_mux_e mux, input logic [4:0] irq, input bit kill);
    ctrl_fetch_t c;
    c         = IDLE;
    c.pc_set  = 1'b1;
    c.pc_mux  = mux;
    c.irq_id  = irq;
    c.kill_if = kill;
    step(c);
    exp_pc = redirect_target(mux, irq);
  endtask

  task automatic run_instrs(input int n);
    int target;
    int i;
    target = n_checked + n;
    i      = 0;
    while (n_checked < target && i < MAX_CYCLES) begin
      step(IDLE);
      i++;
    end
    assert (n_checked >= target)
      else report_error("timeout waiting for instructions from the fetch stage");
  endtask

  task automatic wait_in_flight();
    int i;
    i = 0;
    while (resp_due_q.size() == 0 && i < 100) begin
      step(IDLE);
      i++;
    end
    assert (resp_due_q.size() != 0)
      else report_error("timeout waiting for a read in flight");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic boot_test();
    int k;
    int comp0;
    boot_addr = 32'h1000_0123;
    fill_program(hw_index(32'h0000_0120), 32, 1'b0);
    for (k = 0; k < 3; k++) begin
      step(IDLE);
      assert (!bus_req.req && !if_id.valid && !if_busy)
        else report_error("fetch stage not idle before the first redirect");
    end
    comp0 = n_comp;
    redirect(PC_BOOT, 5'd0, 1'b0);
    run_instrs(12);
    assert (n_comp == comp0) else report_error("compressed instruction in the boot run");
  endtask

  task automatic compressed_test();
    int comp0;
    int str0;
    comp0       = n_comp;
    str0        = n_straddle;
    jump_target = 32'h0000_0401;
    redirect(PC_JUMP, 5'd0, 1'b0);
    run_instrs(40);
    assert (n_comp > comp0 && n_straddle > str0)
      else report_error("program gave no compressed or no straddling instruction");
  endtask

  task automatic redirect_test();
    int i;
    gnt_rand      = 1'b1;
    // Odd halfword targets
    jump_target   = 32'h0000_0336;
    branch_target = 32'h2000_0562;
    mepc          = 32'h0000_02a6;
    mtvec_addr    = 25'h000_4004;
    // Jump through vectored interrupt in enum order
    for (i = 1; i <= 5; i++) begin
      wait_in_flight();
      redirect(pc_mux_e'(i), 5'd13, 1'b0);
      run_instrs(3);
    end
  endtask

  task automatic backpressure_test();
    int stalls0;
    stalls0     = n_stalls;
    ready_rand  = 1'b1;
    jump_target = 32'h0000_0612;
    redirect(PC_JUMP, 5'd0, 1'b0);
    run_instrs(60);
    ready_rand = 1'b0;
    assert (n_stalls > stalls0) else report_error("ID stage never stalled a valid entry");
  endtask

  task automatic halt_kill_test();
    ctrl_fetch_t c;
    int          k;
    jump_target = 32'h0000_0100;
    redirect(PC_JUMP, 5'd0, 1'b0);
    run_instrs(5);
    c         = IDLE;
    c.halt_if = 1'b1;
    for (k = 0; k < 6; k++) begin
      step(c);
      if (k > 0) begin
        assert (!if_id.valid) else report_error("instruction entered IF/ID while halted");
      end
    end
    run_instrs(5);
    mtvec_addr = 25'h000_0008;
    wait_in_flight();
    redirect(PC_TRAP_EXC, 5'd0, 1'b1);
    run_instrs(8);
  endtask

  initial begin
    void'($urandom(79753));
    clk           = 1'b0;
    rst_n         = 1'b0;
    boot_addr     = '0;
    jump_target   = '0;
    branch_target = '0;
    mepc          = '0;
    mtvec_addr    = '0;
    ctrl          = IDLE;
    bus_resp      = '0;
    id_ready      = 1'b1;
    cyc           = 0;
    n_checked     = 0;
    n_comp        = 0;
    n_straddle    = 0;
    n_stalls      = 0;
    exp_pc        = '0;
    exp_last_c    = '0;
    gnt_rand      = 1'b0;
    ready_rand    = 1'b0;
    hold_pending  = 1'b0;
    held          = '0;
    req_pending   = 1'b0;
    req_addr      = '0;
    fill_program(0, MEM_HW, 1'b1);
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    boot_test();
    compressed_test();
    redirect_test();
    backpressure_test();
    halt_kill_test();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

//--- rtl/if_stage.sv
// Instruction fetch stage top with next-PC select, prefetch, alignment and IF/ID register
`timescale 1ns/1ps

module if_stage import fetch_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  // Target addresses
  input  logic [XLEN-1:0]         boot_addr_i,
  input  logic [XLEN-1:0]         jump_target_i,
  input  logic [XLEN-1:0]         branch_target_i,
  input  logic [XLEN-1:0]         mepc_i,
  input  logic [MTVEC_ADDR_W-1:0] mtvec_addr_i,
  input  ctrl_fetch_t             ctrl_i,
  // Instruction bus
  input  bus_resp_t               bus_resp_i,
  output bus_req_t                bus_req_o,
  // ID stage
  input  logic                    id_ready_i,
  output if_id_t                  if_id_o,
  output logic                    if_busy_o,
  output logic                    mtvec_init_o
);

  logic [XLEN-1:0] branch_addr;
  fetch_word_t     fetch_word;
  logic            word_valid;
  logic            word_ready;
  instr_t          aligned;
  logic            instr_valid;
  logic            instr_ready;
  logic [XLEN-1:0] instr_dec;
  logic            illegal_c;
  logic            id_load;

  pc_select pc_select_i (
    .boot_addr_i     (boot_addr_i),
    .jump_target_i   (jump_target_i),
    .branch_target_i (branch_target_i),
    .mepc_i          (mepc_i),
    .mtvec_addr_i    (mtvec_addr_i),
    .ctrl_i          (ctrl_i),
    .branch_addr_o   (branch_addr),
    .mtvec_init_o    (mtvec_init_o)
  );

  prefetch_unit prefetch_unit_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .ctrl_i        (ctrl_i),
    .branch_addr_i (branch_addr),
    .bus_resp_i    (bus_resp_i),
    .bus_req_o     (bus_req_o),
    .word_ready_i  (word_ready),
    .word_o        (fetch_word),
    .word_valid_o  (word_valid),
    .busy_o        (if_busy_o)
  );

  instr_aligner instr_aligner_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .ctrl_i        (ctrl_i),
    .branch_addr_i (branch_addr),
    .word_i        (fetch_word),
    .word_valid_i  (word_valid),
    .word_ready_o  (word_ready),
    .instr_ready_i (instr_ready),
    .instr_o       (aligned),
    .instr_valid_o (instr_valid)
  );

  compressed_decoder compressed_decoder_i (
    .instr_i   (aligned),
    .instr_o   (instr_dec),
    .illegal_o (illegal_c)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Stage handshake and IF/ID register
  ////////////////////////////////////////////////////////////////////////////

  // Kill drains the aligner, halt freezes it
  assign instr_ready = ctrl_i.kill_if || (id_ready_i && !ctrl_i.halt_if);
  assign id_load     = instr_valid && id_ready_i && !ctrl_i.kill_if && !ctrl_i.halt_if;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      if_id_o <= '0;
    end else if (id_load) begin
      if_id_o.valid      <= 1'b1;
      if_id_o.instr      <= instr_dec;
      if_id_o.pc         <= aligned.pc;
      if_id_o.compressed <= aligned.compressed;
      if_id_o.illegal    <= illegal_c;
      // Original halfword kept for compressed instructions only
      if (aligned.compressed) begin
        if_id_o.compressed_instr <= aligned.instr[15:0];
      end
    end else if (id_ready_i) begin
      // ID took the entry and nothing new arrived
      if_id_o.valid <= 1'b0;
    end
  end

  // ID stage sees a held entry while it stalls
  a_if_id_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (if_id_o.valid && !id_ready_i) |=> $stable(if_id_o));

endmodule

//--- rtl/compressed_decoder.sv
// Compressed decoder, expands the supported RVC subset and flags other compressed patterns
`timescale 1ns/1ps

module compressed_decoder
  import fetch_pkg::*;
  import rvc_pkg::*;
(
  input  instr_t          instr_i,
  output logic [XLEN-1:0] instr_o,
  output logic            illegal_o
);

  logic [15:0] c;
  logic [4:0]  rd;
  logic [4:0]  rs2;

  assign c   = instr_i.instr[15:0];
  assign rd  = c[11:7];
  assign rs2 = c[6:2];

  always_comb begin
    // Pass through for 32-bit instructions
    instr_o   = instr_i.instr;
    illegal_o = 1'b0;
    if (instr_i.compressed) begin
      // Unsupported patterns go out as the raw halfword
      instr_o   = {16'h0000, c};
      illegal_o = 1'b1;
      unique case (c[1:0])
        C_Q1: begin
          unique case (c[15:13])
            // c.addi -> addi rd, rd, imm
            C_F3_ADDI: begin
              instr_o   = {{6{c[12]}}, c[12], c[6:2], rd, 3'b000, rd, OPC_OP_IMM};
              illegal_o = 1'b0;
            end
            // c.li -> addi rd, x0, imm
            C_F3_LI: begin
              instr_o   = {{6{c[12]}}, c[12], c[6:2], 5'd0, 3'b000, rd, OPC_OP_IMM};
              illegal_o = 1'b0;
            end
            // c.j -> jal x0, offset
            C_F3_J: begin
              instr_o   = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                           c[12], {8{c[12]}}, 5'd0, OPC_JAL};
              illegal_o = 1'b0;
            end
            default: ;
          endcase
        end
        C_Q2: begin
          // rs2 of zero encodes jr, jalr and ebreak
          if (c[15:13] == C_F4_MV_ADD && rs2 != 5'd0) begin
            illegal_o = 1'b0;
            if (c[12]) begin
              // c.add -> add rd, rd, rs2
              instr_o = {7'b0000000, rs2, rd, 3'b000, rd, OPC_OP};
            end else begin
              // c.mv -> add rd, x0, rs2
              instr_o = {7'b0000000, rs2, 5'd0, 3'b000, rd, OPC_OP};
            end
          end
        end
        default: ;
      endcase
    end
  end

endmodule

//--- rtl/instr_aligner.sv
// Instruction aligner that assembles 16 and 32-bit instructions from fetched words with their PCs
`timescale 1ns/1ps

module instr_aligner
  import fetch_pkg::*;
  import rvc_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  ctrl_fetch_t     ctrl_i,
  input  logic [XLEN-1:0] branch_addr_i,
  // Words from the prefetch unit
  input  fetch_word_t     word_i,
  input  logic            word_valid_i,
  output logic            word_ready_o,
  // Instructions to decode
  input  logic            instr_ready_i,
  output instr_t          instr_o,
  output logic            instr_valid_o
);

  // PC of the next instruction out
  logic [XLEN-1:0] pc_q;
  // Start halfword in the head word
  logic            off_q;
  // Low half of a 32-bit instruction taken from the previous word
  logic            resid_valid_q;
  logic [15:0]     resid_q;

  logic [15:0]     hw;
  logic            hw_is_c;
  logic            stash;
  logic            accept;
  // Address that the head word should carry
  logic [XLEN-1:0] head_addr;

  assign hw      = off_q ? word_i.rdata[31:16] : word_i.rdata[15:0];
  assign hw_is_c = hw[1:0] != C_NOT_COMPRESSED;

  // Upper half that starts a 32-bit instruction moves to the residue
  assign stash = word_valid_i && !resid_valid_q && off_q && !hw_is_c;

  always_comb begin
    instr_o.pc = pc_q;
    if (resid_valid_q) begin
      // Straddling instruction completes with the low half
      instr_o.instr      = {word_i.rdata[15:0], resid_q};
      instr_o.compressed = 1'b0;
    end else if (hw_is_c) begin
      instr_o.instr      = {16'h0000, hw};
      instr_o.compressed = 1'b1;
    end else begin
      instr_o.instr      = word_i.rdata;
      instr_o.compressed = 1'b0;
    end
  end

  assign instr_valid_o = word_valid_i && !stash && !ctrl_i.pc_set;
  assign accept        = instr_valid_o && instr_ready_i;

  // Word is released once its upper half has been used
  assign word_ready_o = stash || (accept && !resid_valid_q && (off_q || !hw_is_c));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q          <= '0;
      off_q         <= 1'b0;
      resid_valid_q <= 1'b0;
    end else if (ctrl_i.pc_set) begin
      // Odd halfword target skips the low half of the first word
      pc_q          <= branch_addr_i;
      off_q         <= branch_addr_i[1];
      resid_valid_q <= 1'b0;
    end else if (stash) begin
      resid_valid_q <= 1'b1;
      off_q         <= 1'b0;
    end else if (accept) begin
      pc_q          <= pc_q + (instr_o.compressed ? XLEN'(2) : XLEN'(4));
      resid_valid_q <= 1'b0;
      // Upper half is next after a straddle or a low compressed half
      off_q         <= resid_valid_q || (!off_q && hw_is_c);
    end
  end

  always_ff @(posedge clk) begin
    if (stash) begin
      resid_q <= hw;
    end
  end

  // Straddle keeps the PC in the previous word
  assign head_addr = resid_valid_q ? pc_q + XLEN'(2) : pc_q;

  // Redirect targets from PC select keep every PC halfword aligned
  a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    instr_valid_o |-> !instr_o.pc[0]);

  // Prefetch order matches the instruction stream
  a_word_addr: assert property (@(posedge clk) disable iff (!rst_n)
    (word_valid_i && !ctrl_i.pc_set) |-> (word_i.addr[XLEN-1:2] == head_addr[XLEN-1:2]));

endmodule

//--- rtl/prefetch_unit.sv
// Prefetch unit, issues word reads on the instruction bus and buffers the returned words
`timescale 1ns/1ps

module prefetch_unit import fetch_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  ctrl_fetch_t     ctrl_i,
  input  logic [XLEN-1:0] branch_addr_i,
  // Instruction bus
  input  bus_resp_t       bus_resp_i,
  output bus_req_t        bus_req_o,
  // Words to the aligner
  input  logic            word_ready_i,
  output fetch_word_t     word_o,
  output logic            word_valid_o,
  output logic            busy_o
);

  // Fetching enabled after the first redirect
  logic                 active_q;
  // Address of the next request
  logic [XLEN-1:0]      fetch_addr_q;
  // Address of the next response that is kept
  logic [XLEN-1:0]      resp_addr_q;
  // Reads in flight, stale ones included
  logic [CNT_W-1:0]     out_cnt_q;
  // Stale reads still to be dropped
  logic [CNT_W-1:0]     drop_cnt_q;
  // Buffered words
  logic [CNT_W-1:0]     fill_q;
  logic [BUF_PTR_W-1:0] wr_ptr_q;
  logic [BUF_PTR_W-1:0] rd_ptr_q;
  fetch_word_t          buf_q [FIFO_DEPTH];

  logic credit_ok;
  logic grant;
  logic resp_drop;
  logic push;
  logic pop;

  ////////////////////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////////////////////

  // Buffered plus outstanding must stay below the depth
  assign credit_ok = ({1'b0, fill_q} + {1'b0, out_cnt_q}) < (CNT_W + 1)'(FIFO_DEPTH);

  // No request in the redirect cycle, the address is about to change
  assign bus_req_o.req  = active_q && credit_ok && !ctrl_i.pc_set;
  assign bus_req_o.addr = fetch_addr_q;
  assign grant          = bus_req_o.req && bus_resp_i.gnt;

  ////////////////////////////////////////////////////////////////////////////
  // Response side and buffer
  ////////////////////////////////////////////////////////////////////////////

  assign resp_drop    = bus_resp_i.rvalid && (drop_cnt_q != '0);
  assign push         = bus_resp_i.rvalid && !resp_drop && !ctrl_i.pc_set;
  assign word_valid_o = fill_q != '0;
  assign word_o       = buf_q[rd_ptr_q];
  assign pop          = word_valid_o && word_ready_i && !ctrl_i.pc_set;
  assign busy_o       = out_cnt_q != '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active_q     <= 1'b0;
      fetch_addr_q <= '0;
      resp_addr_q  <= '0;
      out_cnt_q    <= '0;
      drop_cnt_q   <= '0;
      fill_q       <= '0;
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
    end else begin
      // Grant and response are independent
      out_cnt_q <= out_cnt_q + CNT_W'(grant) - CNT_W'(bus_resp_i.rvalid);
      if (ctrl_i.pc_set) begin
        active_q     <= 1'b1;
        fetch_addr_q <= {branch_addr_i[XLEN-1:2], 2'b00};
        resp_addr_q  <= {branch_addr_i[XLEN-1:2], 2'b00};
        // Every read still in flight now belongs to the old path
        drop_cnt_q   <= out_cnt_q - CNT_W'(bus_resp_i.rvalid);
        fill_q       <= '0;
        wr_ptr_q     <= '0;
        rd_ptr_q     <= '0;
      end else begin
        if (grant) begin
          fetch_addr_q <= fetch_addr_q + XLEN'(4);
        end
        if (resp_drop) begin
          drop_cnt_q <= drop_cnt_q - CNT_W'(1);
        end
        if (push) begin
          resp_addr_q <= resp_addr_q + XLEN'(4);
          wr_ptr_q    <= wr_ptr_q + 1'b1;
        end
        if (pop) begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
        fill_q <= fill_q + CNT_W'(push) - CNT_W'(pop);
      end
    end
  end

  // Word storage
  always_ff @(posedge clk) begin
    if (push) begin
      buf_q[wr_ptr_q] <= '{rdata: bus_resp_i.rdata, addr: resp_addr_q};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Credit accounting holds reads in flight to the depth
  a_out_cnt_bound: assert property (@(posedge clk) disable iff (!rst_n)
    out_cnt_q <= CNT_W'(FIFO_DEPTH));

  // Bus only answers reads it granted
  a_rvalid_expected: assert property (@(posedge clk) disable iff (!rst_n)
    bus_resp_i.rvalid |-> (out_cnt_q != '0));

endmodule

//--- rtl/pc_select.sv
// PC select, picks the fetch redirect target and flags mtvec initialization on boot
`timescale 1ns/1ps

module pc_select import fetch_pkg::*; (
  // Candidate targets
  input  logic [XLEN-1:0]         boot_addr_i,
  input  logic [XLEN-1:0]         jump_target_i,
  input  logic [XLEN-1:0]         branch_target_i,
  input  logic [XLEN-1:0]         mepc_i,
  input  logic [MTVEC_ADDR_W-1:0] mtvec_addr_i,
  // Controller request
  input  ctrl_fetch_t             ctrl_i,
  // Selected target, halfword aligned
  output logic [XLEN-1:0]         branch_addr_o,
  output logic                    mtvec_init_o
);

  logic [XLEN-1:0] target;

  always_comb begin
    unique case (ctrl_i.pc_mux)
      PC_BOOT:     target = {boot_addr_i[XLEN-1:2], 2'b00};
      PC_JUMP:     target = jump_target_i;
      PC_BRANCH:   target = branch_target_i;
      // Return from trap
      PC_MRET:     target = mepc_i;
      // Exceptions share the trap base
      PC_TRAP_EXC: target = {mtvec_addr_i, 7'h00};
      // Interrupts are vectored by index
      PC_TRAP_IRQ: target = {mtvec_addr_i, ctrl_i.irq_id, 2'b00};
      // Unused encodings fall back to boot
      default:     target = {boot_addr_i[XLEN-1:2], 2'b00};
    endcase
  end

  // Fetch never starts on an odd byte
  assign branch_addr_o = {target[XLEN-1:1], 1'b0};

  // CSR file loads mtvec on the boot redirect
  assign mtvec_init_o = ctrl_i.pc_set && (ctrl_i.pc_mux == PC_BOOT);

endmodule

//--- rtl/rvc_pkg.sv
// RVC package with opcode and field constants for compressed and expanded encodings
package rvc_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Expanded 32-bit opcodes
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  ////////////////////////////////////////////////////////////////////////////
  // Compressed encoding
  ////////////////////////////////////////////////////////////////////////////

  // Low two bits of any 32-bit instruction
  localparam logic [1:0] C_NOT_COMPRESSED = 2'b11;

  // Quadrants
  localparam logic [1:0] C_Q1 = 2'b01;
  localparam logic [1:0] C_Q2 = 2'b10;

  // Quadrant 1 funct3
  localparam logic [2:0] C_F3_ADDI = 3'b000;
  localparam logic [2:0] C_F3_LI   = 3'b010;
  localparam logic [2:0] C_F3_J    = 3'b101;

  // Quadrant 2 funct4 upper bits, bit 12 picks MV (0) or ADD (1)
  localparam logic [2:0] C_F4_MV_ADD = 3'b100;

endpackage

//--- rtl/fetch_pkg.sv
// Fetch stage package with control, bus and pipeline types shared by the fetch units
package fetch_pkg;

  // Data and address width
  localparam int XLEN         = 32;
  // Trap base field and interrupt index widths
  localparam int MTVEC_ADDR_W = 25;
  localparam int IRQ_ID_W     = 5;
  // Prefetch buffer slots, also the credit limit for reads in flight
  localparam int FIFO_DEPTH   = 2;
  // Counter width for values 0..FIFO_DEPTH
  localparam int CNT_W        = $clog2(FIFO_DEPTH + 1);
  // Buffer slot index width
  localparam int BUF_PTR_W    = $clog2(FIFO_DEPTH);

  // Next-PC source
  typedef enum logic [2:0] {
    PC_BOOT,
    PC_JUMP,
    PC_BRANCH,
    PC_MRET,
    PC_TRAP_EXC,
    PC_TRAP_IRQ
  } pc_mux_e;

  // Controller to fetch stage
  typedef struct packed {
    logic                pc_set;
    pc_mux_e             pc_mux;
    logic                kill_if;
    logic                halt_if;
    logic [IRQ_ID_W-1:0] irq_id;
  } ctrl_fetch_t;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction bus
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic            req;
    logic [XLEN-1:0] addr;
  } bus_req_t;

  typedef struct packed {
    logic            gnt;
    logic            rvalid;
    logic [XLEN-1:0] rdata;
  } bus_resp_t;

  ////////////////////////////////////////////////////////////////////////////
  // Internal fetch path
  ////////////////////////////////////////////////////////////////////////////

  // Fetched word with its word address
  typedef struct packed {
    logic [XLEN-1:0] rdata;
    logic [XLEN-1:0] addr;
  } fetch_word_t;

  // Aligned instruction, still in raw form
  typedef struct packed {
    logic [31:0]     instr;
    logic [XLEN-1:0] pc;
    logic            compressed;
  } instr_t;

  // IF/ID pipeline register contents
  typedef struct packed {
    logic            valid;
    logic [31:0]     instr;
    logic [XLEN-1:0] pc;
    logic            compressed;
    logic            illegal;
    logic [15:0]     compressed_instr;
  } if_id_t;

endpackage
